// File: src/mipsPkg.sv
////////////////////////////////////////////////////////////////////////////
// shared widths, opcode/function/ALU/forwarding enums and the
// packed structs carried between the pipeline stages
////////////////////////////////////////////////////////////////////////////
package mipsPkg;

	// datapath and memory sizes
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int dmemWords = 64;
	localparam int dmemAddrWidth = $clog2(dmemWords);

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		rType  = 6'h00,
		addiOp = 6'h08,
		lwOp   = 6'h23,
		swOp   = 6'h2b
	} opcodeT;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		addFn = 6'h20,
		subFn = 6'h22,
		andFn = 6'h24,
		orFn  = 6'h25,
		sltFn = 6'h2a
	} functT;

	// classic 3-bit ALU control encoding
	typedef enum logic [2:0] {
		aluAnd = 3'b000,
		aluOr  = 3'b001,
		aluAdd = 3'b010,
		aluSub = 3'b110,
		aluSlt = 3'b111
	} aluOpT;

	// EX operand source
	typedef enum logic [1:0] {
		fwdNone = 2'b00,
		fwdWb   = 2'b01,
		fwdMem  = 2'b10
	} fwdSelT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic regDst;
		logic aluSrc;
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		logic [dataWidth-1:0] instr;
		logic [dataWidth-1:0] pcPlus4;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] signImm;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
	} idExT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic [dataWidth-1:0] aluOut;
		logic [dataWidth-1:0] writeData;
		logic [regAddrWidth-1:0] writeReg;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic [dataWidth-1:0] aluOut;
		logic [dataWidth-1:0] readData;
		logic [regAddrWidth-1:0] writeReg;
	} memWbT;

endpackage : mipsPkg

// File: src/pipeRegs.sv
////////////////////////////////////////////////////////////////////////////
// pipeline stage registers: PC, IF/ID, ID/EX, EX/MEM and MEM/WB
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

// fetch address register
module pcIf import mipsPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic stall,
	input  logic clear,
	input  logic [dataWidth-1:0] pcNext,
	output logic [dataWidth-1:0] pcF
);
	// reset and clear both restart fetch at address 0
	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			pcF <= '0;
		end else if (!stall) begin
			pcF <= pcNext;
		end
	end
endmodule : pcIf

// holds the fetched word for decode
module ifId import mipsPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic stall,
	input  logic clear,
	input  ifIdT inD,
	output ifIdT outD
);
	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			outD <= '0;
		end else if (!stall) begin
			outD <= inD;
		end
	end
endmodule : ifId

// decode to execute
module idEx import mipsPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic stall,
	input  logic clear,
	input  idExT inE,
	output idExT outE
);
	// clear drops a bubble, all control bits zero
	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			outE <= '0;
		end else if (!stall) begin
			outE <= inE;
		end
	end
endmodule : idEx

// execute to memory
module exMem import mipsPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic stall,
	input  logic clear,
	input  exMemT inM,
	output exMemT outM
);
	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			outM <= '0;
		end else if (!stall) begin
			outM <= inM;
		end
	end
endmodule : exMem

// memory to writeback
module memWb import mipsPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic stall,
	input  logic clear,
	input  memWbT inW,
	output memWbT outW
);
	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			outW <= '0;
		end else if (!stall) begin
			outW <= inW;
		end
	end

	// only loads select memory data, and a load always writes back
	// (a store reaching WB must carry neither bit)
	memDataOnlyFromLoad: assert property (@(posedge clk) disable iff (!rstN)
		outW.memToReg |-> outW.regWrite);
endmodule : memWb

// File: src/controlUnit.sv
////////////////////////////////////////////////////////////////////////////
// main decoder: opcode and function fields to the control struct
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module controlUnit import mipsPkg::*; (
	input  opcodeT opcode,
	input  functT funct,
	output ctrlT ctrl
);
	always_comb begin
		// anything not listed decodes as a nop
		ctrl = '0;
		case (opcode)
			rType: begin
				// result goes to rd, both operands from registers
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				case (funct)
					addFn: ctrl.aluOp = aluAdd;
					subFn: ctrl.aluOp = aluSub;
					andFn: ctrl.aluOp = aluAnd;
					orFn: ctrl.aluOp = aluOr;
					sltFn: ctrl.aluOp = aluSlt;
					default: ctrl = '0;
				endcase
			end
			addiOp: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			lwOp: begin
				// address = rs + imm, data to rt
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			swOp: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			default: ctrl = '0;
		endcase
	end
endmodule : controlUnit

// File: src/regFile.sv
////////////////////////////////////////////////////////////////////////////
// 32 x 32 register file, two read ports, one write port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic we,
	input  logic [regAddrWidth-1:0] wa,
	input  logic [dataWidth-1:0] wd,
	input  logic [regAddrWidth-1:0] ra1,
	input  logic [regAddrWidth-1:0] ra2,
	output logic [dataWidth-1:0] rd1,
	output logic [dataWidth-1:0] rd2
);
	logic [dataWidth-1:0] regs [1 << regAddrWidth];

	// registers start at zero after reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < (1 << regAddrWidth); i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// r0 is hardwired zero
	// same-cycle write shows through to decode
	assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];
endmodule : regFile

// File: src/alu.sv
////////////////////////////////////////////////////////////////////////////
// integer ALU for add, sub, and, or and signed slt
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alu import mipsPkg::*; (
	input  aluOpT op,
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	output logic [dataWidth-1:0] y
);
	logic lessThan;

	// signed compare for slt
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			aluAdd: y = a + b;
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr: y = a | b;
			// result is 0 or 1
			aluSlt: y = {{(dataWidth-1){1'b0}}, lessThan};
			default: y = '0;
		endcase
	end
endmodule : alu

// File: src/hazardUnit.sv
////////////////////////////////////////////////////////////////////////////
// EX forwarding selects and load-use stall detection
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
	input  logic [regAddrWidth-1:0] rsD,
	input  logic [regAddrWidth-1:0] rtD,
	input  logic [regAddrWidth-1:0] rsE,
	input  logic [regAddrWidth-1:0] rtE,
	input  logic memToRegE,
	input  logic [regAddrWidth-1:0] writeRegM,
	input  logic regWriteM,
	input  logic [regAddrWidth-1:0] writeRegW,
	input  logic regWriteW,
	output fwdSelT forwardA,
	output fwdSelT forwardB,
	output logic stallF,
	output logic stallD,
	output logic flushE
);
	logic lwStall;

	// newer result in MEM wins over WB
	always_comb begin
		forwardA = fwdNone;
		if (regWriteM && writeRegM != '0 && writeRegM == rsE) forwardA = fwdMem;
		else if (regWriteW && writeRegW != '0 && writeRegW == rsE) forwardA = fwdWb;

		forwardB = fwdNone;
		if (regWriteM && writeRegM != '0 && writeRegM == rtE) forwardB = fwdMem;
		else if (regWriteW && writeRegW != '0 && writeRegW == rtE) forwardB = fwdWb;
	end

	// load in EX targets rt; decode needs it one cycle too early
	assign lwStall = memToRegE && rtE != '0 && (rtE == rsD || rtE == rtD);

	// hold PC and IF/ID, bubble into EX
	assign stallF = lwStall;
	assign stallD = lwStall;
	assign flushE = lwStall;
endmodule : hazardUnit

// File: src/dataMem.sv
////////////////////////////////////////////////////////////////////////////
// 64-word data memory, word addressed
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module dataMem import mipsPkg::*; (
	input  logic clk,
	input  logic we,
	input  logic [dataWidth-1:0] addr,
	input  logic [dataWidth-1:0] wd,
	output logic [dataWidth-1:0] rd
);
	logic [dataWidth-1:0] mem [dmemWords];
	logic [dmemAddrWidth-1:0] wordAddr;

	// byte address bits 1:0 ignored, upper bits wrap
	assign wordAddr = addr[dmemAddrWidth+1:2];

	// combinational read
	assign rd = mem[wordAddr];

	always_ff @(posedge clk) begin
		if (we) mem[wordAddr] <= wd;
	end
endmodule : dataMem

// File: src/mipsCore.sv
////////////////////////////////////////////////////////////////////////////
// five-stage MIPS subset core: fetch, decode, execute, memory and
// writeback with forwarding and load-use stall
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic [dataWidth-1:0] imemData,
	output logic [dataWidth-1:0] imemAddr,
	output logic wbValid,
	output logic [regAddrWidth-1:0] wbReg,
	output logic [dataWidth-1:0] wbData
);
	// fetch
	logic [dataWidth-1:0] pcF, pcPlus4F;
	ifIdT ifIdIn, ifIdOut;
	// decode
	ctrlT ctrlD;
	logic [dataWidth-1:0] rd1D, rd2D, signImmD;
	idExT idExIn, idExOut;
	// execute
	logic [regAddrWidth-1:0] writeRegE;
	logic [dataWidth-1:0] srcAE, srcBE, writeDataE, aluOutE;
	exMemT exMemIn, exMemOut;
	// memory
	logic [dataWidth-1:0] readDataM;
	memWbT memWbIn, memWbOut;
	// writeback
	logic [dataWidth-1:0] resultW;
	// hazards
	fwdSelT forwardA, forwardB;
	logic stallF, stallD, flushE;

	// no branches, so next PC is always sequential
	assign pcPlus4F = pcF + 32'd4;
	assign imemAddr = pcF;

	pcIf pcIf_inst (.clk(clk), .rstN(rstN), .stall(stallF), .clear(1'b0),
		.pcNext(pcPlus4F), .pcF(pcF));

	assign ifIdIn.instr = imemData;
	assign ifIdIn.pcPlus4 = pcPlus4F;

	ifId ifId_inst (.clk(clk), .rstN(rstN), .stall(stallD), .clear(1'b0),
		.inD(ifIdIn), .outD(ifIdOut));

	controlUnit controlUnit_inst (
		.opcode(opcodeT'(ifIdOut.instr[31:26])),
		.funct(functT'(ifIdOut.instr[5:0])),
		.ctrl(ctrlD)
	);

	regFile regFile_inst (.clk(clk), .rstN(rstN), .we(wbValid), .wa(memWbOut.writeReg),
		.wd(resultW), .ra1(ifIdOut.instr[25:21]), .ra2(ifIdOut.instr[20:16]),
		.rd1(rd1D), .rd2(rd2D));

	assign signImmD = {{16{ifIdOut.instr[15]}}, ifIdOut.instr[15:0]};

	assign idExIn.ctrl = ctrlD;
	assign idExIn.a = rd1D;
	assign idExIn.b = rd2D;
	assign idExIn.signImm = signImmD;
	assign idExIn.rs = ifIdOut.instr[25:21];
	assign idExIn.rt = ifIdOut.instr[20:16];
	assign idExIn.rd = ifIdOut.instr[15:11];

	idEx idEx_inst (.clk(clk), .rstN(rstN), .stall(1'b0), .clear(flushE),
		.inE(idExIn), .outE(idExOut));

	// R-type writes rd, immediates and loads write rt
	assign writeRegE = idExOut.ctrl.regDst ? idExOut.rd : idExOut.rt;

	// operand muxes, forwarded values override register reads
	always_comb begin
		case (forwardA)
			fwdMem: srcAE = exMemOut.aluOut;
			fwdWb: srcAE = resultW;
			default: srcAE = idExOut.a;
		endcase
		case (forwardB)
			fwdMem: writeDataE = exMemOut.aluOut;
			fwdWb: writeDataE = resultW;
			default: writeDataE = idExOut.b;
		endcase
	end

	// store data keeps the forwarded rt, B takes the immediate
	assign srcBE = idExOut.ctrl.aluSrc ? idExOut.signImm : writeDataE;

	alu alu_inst (.op(idExOut.ctrl.aluOp), .a(srcAE), .b(srcBE), .y(aluOutE));

	assign exMemIn.regWrite = idExOut.ctrl.regWrite;
	assign exMemIn.memToReg = idExOut.ctrl.memToReg;
	assign exMemIn.memWrite = idExOut.ctrl.memWrite;
	assign exMemIn.aluOut = aluOutE;
	assign exMemIn.writeData = writeDataE;
	assign exMemIn.writeReg = writeRegE;

	exMem exMem_inst (.clk(clk), .rstN(rstN), .stall(1'b0), .clear(1'b0),
		.inM(exMemIn), .outM(exMemOut));

	dataMem dataMem_inst (.clk(clk), .we(exMemOut.memWrite), .addr(exMemOut.aluOut),
		.wd(exMemOut.writeData), .rd(readDataM));

	assign memWbIn.regWrite = exMemOut.regWrite;
	assign memWbIn.memToReg = exMemOut.memToReg;
	assign memWbIn.aluOut = exMemOut.aluOut;
	assign memWbIn.readData = readDataM;
	assign memWbIn.writeReg = exMemOut.writeReg;

	memWb memWb_inst (.clk(clk), .rstN(rstN), .stall(1'b0), .clear(1'b0),
		.inW(memWbIn), .outW(memWbOut));

	assign resultW = memWbOut.memToReg ? memWbOut.readData : memWbOut.aluOut;

	// writes to r0 are dropped and not reported
	assign wbValid = memWbOut.regWrite && memWbOut.writeReg != '0;
	assign wbReg = memWbOut.writeReg;
	assign wbData = resultW;

	hazardUnit hazardUnit_inst (
		.rsD(ifIdOut.instr[25:21]), .rtD(ifIdOut.instr[20:16]),
		.rsE(idExOut.rs), .rtE(idExOut.rt), .memToRegE(idExOut.ctrl.memToReg),
		.writeRegM(exMemOut.writeReg), .regWriteM(exMemOut.regWrite),
		.writeRegW(memWbOut.writeReg), .regWriteW(memWbOut.regWrite),
		.forwardA(forwardA), .forwardB(forwardB),
		.stallF(stallF), .stallD(stallD), .flushE(flushE)
	);

	// PC and IF/ID stall together, so decode always sees the word fetched from pcF - 4
	fetchDecodeInStep: assert property (@(posedge clk) disable iff (!rstN)
		ifIdOut.pcPlus4 == pcF);
endmodule : mipsCore

// File: verification/mipsCoreTb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the five-stage core: program table, reference model,
// instruction memory responder, writeback monitor and watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mipsCoreTb import mipsPkg::*; ();

	// one program entry with what the model expects from it
	typedef struct packed {
		logic [dataWidth-1:0] instr;
		logic writes;
		logic [regAddrWidth-1:0] expReg;
		logic [dataWidth-1:0] expData;
	} progEntryT;

	logic clk;
	logic rstN;
	logic [dataWidth-1:0] imemData;
	logic [dataWidth-1:0] imemAddr;
	logic wbValid;
	logic [regAddrWidth-1:0] wbReg;
	logic [dataWidth-1:0] wbData;

	progEntryT prog [$];
	logic [dataWidth-1:0] fetchIdx;
	logic modelReady;
	int nextIdx;
	int expCount;
	int seenCount;

	mipsCore mipsCore_inst (.clk(clk), .rstN(rstN), .imemData(imemData),
		.imemAddr(imemAddr), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData));

	always #10 clk = ~clk;

	// stops the run at the first mismatch
	task automatic checkEq(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// R-type word: rs, rt, rd, shamt 0, funct
	function automatic logic [31:0] rInstr(functT fn, int rd, int rs, int rt);
		return {rType, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	// I-type word: opcode, rs, rt, 16-bit immediate
	function automatic logic [31:0] iInstr(opcodeT op, int rt, int rs, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	task automatic addInstr(input logic [31:0] word);
		progEntryT e;
		e = '0;
		e.instr = word;
		prog.push_back(e);
	endtask

	task automatic buildProgram();
		// operands, one random, one forced negative
		addInstr(iInstr(addiOp, 1, 0, 16'($urandom)));
		addInstr(iInstr(addiOp, 2, 0, 16'($urandom)));
		addInstr(iInstr(addiOp, 3, 0, 16'($urandom) | 16'h8000));
		// forwarding chain, MEM and WB sources mixed
		addInstr(rInstr(addFn, 4, 1, 2));
		addInstr(rInstr(subFn, 5, 4, 3));
		addInstr(rInstr(andFn, 6, 5, 1));
		addInstr(rInstr(orFn, 7, 6, 4));
		// signed compare both ways
		addInstr(rInstr(sltFn, 8, 3, 1));
		addInstr(rInstr(sltFn, 9, 1, 3));
		addInstr(iInstr(addiOp, 10, 9, 16'($urandom)));
		// store then load back the same word
		addInstr(iInstr(swOp, 7, 0, 16'd8));
		addInstr(iInstr(swOp, 5, 0, 16'd12));
		addInstr(iInstr(lwOp, 11, 0, 16'd8));
		// load-use: the add has to wait one cycle
		addInstr(rInstr(addFn, 12, 11, 1));
		addInstr(iInstr(lwOp, 13, 0, 16'd12));
		addInstr(iInstr(swOp, 13, 0, 16'd16));
		addInstr(iInstr(lwOp, 14, 0, 16'd16));
		addInstr(rInstr(subFn, 15, 14, 13));
		// store data forwarded straight from the producer
		addInstr(iInstr(addiOp, 26, 2, 16'($urandom)));
		addInstr(iInstr(swOp, 26, 0, 16'd20));
		addInstr(iInstr(lwOp, 27, 0, 16'd20));
		// writes to r0 vanish, reads of r0 give zero
		addInstr(iInstr(addiOp, 0, 1, 16'd5));
		addInstr(rInstr(addFn, 0, 1, 2));
		addInstr(rInstr(orFn, 16, 0, 1));
		addInstr(rInstr(addFn, 17, 0, 0));
		addInstr(rInstr(sltFn, 18, 2, 2));
		addInstr(iInstr(addiOp, 19, 0, 16'hffff));
		addInstr(rInstr(sltFn, 20, 19, 0));
		// random immediates chained through r20
		for (int k = 0; k < 4; k++) begin
			addInstr(iInstr(addiOp, 21 + k, 20 + k, 16'($urandom)));
		end
		addInstr(rInstr(addFn, 25, 21, 24));
	endtask

	// ISA-level model: fills the expected fields of each table entry
	task automatic runModel();
		logic [31:0] regs [32];
		logic [31:0] mem [dmemWords];
		logic [31:0] instr, a, b, imm, res, addrW;
		logic [regAddrWidth-1:0] rs, rt, rd, dest;
		logic doWrite;
		for (int i = 0; i < 32; i++) regs[i] = '0;
		for (int i = 0; i < dmemWords; i++) mem[i] = '0;
		expCount = 0;
		foreach (prog[i]) begin
			instr = prog[i].instr;
			rs = instr[25:21];
			rt = instr[20:16];
			rd = instr[15:11];
			a = regs[rs];
			b = regs[rt];
			imm = {{16{instr[15]}}, instr[15:0]};
			doWrite = 1'b0;
			dest = '0;
			res = '0;
			case (opcodeT'(instr[31:26]))
				rType: begin
					dest = rd;
					doWrite = 1'b1;
					case (functT'(instr[5:0]))
						addFn: res = a + b;
						subFn: res = a - b;
						andFn: res = a & b;
						orFn: res = a | b;
						sltFn: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: doWrite = 1'b0;
					endcase
				end
				addiOp: begin
					dest = rt;
					doWrite = 1'b1;
					res = a + imm;
				end
				lwOp: begin
					dest = rt;
					doWrite = 1'b1;
					addrW = a + imm;
					res = mem[addrW[7:2]];
				end
				swOp: begin
					addrW = a + imm;
					mem[addrW[7:2]] = b;
				end
				default: ;
			endcase
			// r0 stays zero and is never reported
			if (doWrite && dest != '0) begin
				regs[dest] = res;
				prog[i].writes = 1'b1;
				prog[i].expReg = dest;
				prog[i].expData = res;
				expCount++;
			end
		end
	endtask

	// instruction memory answers the current fetch address
	always @(negedge clk) begin
		fetchIdx = imemAddr >> 2;
		if (fetchIdx < prog.size()) imemData <= prog[fetchIdx].instr;
		else imemData <= '0;
	end

	// writeback monitor, strictly in program order
	always @(negedge clk) begin
		if (modelReady && wbValid) begin
			// entries without a register write produce no writeback
			while (nextIdx < prog.size() && !prog[nextIdx].writes) begin
				nextIdx++;
			end
			if (nextIdx >= prog.size()) begin
				$display("unexpected writeback to r%0d after the last expected one", wbReg);
				$display("Result: FAILED");
				$fatal(1, "extra writeback");
			end else begin
				checkEq("wbReg", 32'(wbReg), 32'(prog[nextIdx].expReg));
				checkEq("wbData", wbData, prog[nextIdx].expData);
				nextIdx++;
				seenCount++;
			end
		end
	end

	// bound from the table length: two cycles per entry plus slack
	initial begin
		wait (modelReady);
		repeat (4 + 2 * prog.size() + 20) @(posedge clk);
		$display("timeout: writebacks did not finish, %0d of %0d seen", seenCount, expCount);
		$display("Result: FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		imemData = '0;
		modelReady = 1'b0;
		nextIdx = 0;
		seenCount = 0;
		void'($urandom(32'h7022_b610));
		buildProgram();
		runModel();
		modelReady = 1'b1;

		// reset held over 4 rising edges, fetch parked at 0
		repeat (4) begin
			@(negedge clk);
			checkEq("imemAddr", imemAddr, 32'h0);
			checkEq("wbValid", 32'(wbValid), 32'h0);
		end
		rstN = 1'b1;
		checkEq("imemAddr", imemAddr, 32'h0);
		@(negedge clk);
		checkEq("imemAddr", imemAddr, 32'h4);
		checkEq("wbValid", 32'(wbValid), 32'h0);

		while (seenCount != expCount) @(negedge clk);
		// trailing nops must not write anything
		repeat (8) @(negedge clk);
		$display("Result: PASSED");
		$finish;
	end

endmodule : mipsCoreTb

// File: vlog.f
src/mipsPkg.sv
src/pipeRegs.sv
src/controlUnit.sv
src/regFile.sv
src/alu.sv
src/hazardUnit.sv
src/dataMem.sv
src/mipsCore.sv
verification/mipsCoreTb.sv

// File: Makefile
# Verilator build and run for the MIPS core testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --timescale 1ns/1ps \
		--top-module mipsCoreTb -f vlog.f -Mdir obj_dir -o simv

run: compile
	./obj_dir/simv 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
